// File: hw/rv_isa_pkg.sv
package rv_isa_pkg;

   // Major opcodes
   localparam logic [6:0] OPC_LOAD  = 7'b0000011;
   localparam logic [6:0] OPC_STORE = 7'b0100011;

   // funct3 of loads and stores, the unsigned forms are loads only
   localparam logic [2:0] F3_B  = 3'b000;
   localparam logic [2:0] F3_H  = 3'b001;
   localparam logic [2:0] F3_W  = 3'b010;
   localparam logic [2:0] F3_D  = 3'b011;
   localparam logic [2:0] F3_BU = 3'b100;
   localparam logic [2:0] F3_HU = 3'b101;
   localparam logic [2:0] F3_WU = 3'b110;

   // Access size in bytes
   typedef logic [3:0] access_size_t;

   localparam access_size_t SIZE_B = 4'd1;
   localparam access_size_t SIZE_H = 4'd2;
   localparam access_size_t SIZE_W = 4'd4;
   localparam access_size_t SIZE_D = 4'd8;

   typedef logic [4:0]  reg_idx_t;
   typedef logic [63:0] xlen_t;

   typedef struct packed {
      logic         valid;
      logic         load;
      logic         store;
      logic         sigext;
      access_size_t size;
      reg_idx_t     rd;
      xlen_t        imm;
      xlen_t        rs1_val;
      xlen_t        rs2_val;
   } lsu_op_t;

endpackage

// File: hw/mem_pkg.sv
package mem_pkg;

   typedef logic [63:0] dword_t;

   // One enable per byte lane
   typedef logic [7:0] byte_en_t;

   typedef struct packed {
      logic                     valid;
      logic                     load;
      logic                     store;
      logic                     sigext;
      rv_isa_pkg::access_size_t size;
      rv_isa_pkg::reg_idx_t     rd;
      rv_isa_pkg::xlen_t        addr;
      rv_isa_pkg::xlen_t        wdata;
   } lsu_req_t;

   typedef struct packed {
      logic                 valid;
      rv_isa_pkg::reg_idx_t rd;
      rv_isa_pkg::xlen_t    data;
   } wb_t;

endpackage

// File: hw/lsu_decode.sv
`timescale 1ns/100ps

module lsu_decode (
   input  logic                i_clk,
   input  logic                i_rst,
   input  logic                i_valid,
   input  logic [31:0]         i_insn,
   input  rv_isa_pkg::xlen_t   i_rs1_val,
   input  rv_isa_pkg::xlen_t   i_rs2_val,
   output rv_isa_pkg::lsu_op_t o_op
);

   logic [6:0]          opcode;
   logic [2:0]          funct3;
   logic                is_load;
   logic                is_store;
   logic                legal;
   rv_isa_pkg::lsu_op_t op_d;

   assign opcode   = i_insn[6:0];
   assign funct3   = i_insn[14:12];
   assign is_load  = (opcode == rv_isa_pkg::OPC_LOAD);
   assign is_store = (opcode == rv_isa_pkg::OPC_STORE);

   always_comb
   begin
      legal       = 1'b1;
      op_d.sigext = 1'b0;
      op_d.size   = rv_isa_pkg::SIZE_D;
      case (funct3)
         rv_isa_pkg::F3_B:
         begin
            op_d.size   = rv_isa_pkg::SIZE_B;
            op_d.sigext = 1'b1;
         end
         rv_isa_pkg::F3_H:
         begin
            op_d.size   = rv_isa_pkg::SIZE_H;
            op_d.sigext = 1'b1;
         end
         rv_isa_pkg::F3_W:
         begin
            op_d.size   = rv_isa_pkg::SIZE_W;
            op_d.sigext = 1'b1;
         end
         rv_isa_pkg::F3_D:
            op_d.size = rv_isa_pkg::SIZE_D;
         rv_isa_pkg::F3_BU:
            op_d.size = rv_isa_pkg::SIZE_B;
         rv_isa_pkg::F3_HU:
            op_d.size = rv_isa_pkg::SIZE_H;
         rv_isa_pkg::F3_WU:
            op_d.size = rv_isa_pkg::SIZE_W;
         default:
            legal = 1'b0;
      endcase
      // Stores have no unsigned forms
      if (is_store && funct3[2])
         legal = 1'b0;

      op_d.valid   = i_valid & (is_load | is_store) & legal;
      op_d.load    = is_load;
      op_d.store   = is_store;
      op_d.rd      = i_insn[11:7];
      // I-type immediate for loads, S-type for stores
      op_d.imm     = is_store ? {{52{i_insn[31]}}, i_insn[31:25], i_insn[11:7]}
                              : {{52{i_insn[31]}}, i_insn[31:20]};
      op_d.rs1_val = i_rs1_val;
      op_d.rs2_val = i_rs2_val;
   end

   always_ff @(posedge i_clk)
   begin
      o_op <= op_d;
      if (i_rst)
         o_op.valid <= 1'b0;
   end

endmodule

// File: hw/lsu_agu.sv
`timescale 1ns/100ps

module lsu_agu (
   input  logic                i_clk,
   input  logic                i_rst,
   input  rv_isa_pkg::lsu_op_t i_op,
   output mem_pkg::lsu_req_t   o_req
);

   mem_pkg::lsu_req_t req_d;

   always_comb
   begin
      req_d.valid  = i_op.valid;
      req_d.load   = i_op.load;
      req_d.store  = i_op.store;
      req_d.sigext = i_op.sigext;
      req_d.size   = i_op.size;
      req_d.rd     = i_op.rd;
      // Effective address
      req_d.addr   = i_op.rs1_val + i_op.imm;
      req_d.wdata  = i_op.rs2_val;
   end

   always_ff @(posedge i_clk)
   begin
      o_req <= req_d;
      if (i_rst)
         o_req.valid <= 1'b0;
   end

endmodule

// File: hw/lsu.sv
`timescale 1ns/100ps

module lsu #(
   parameter int DRAM_AW = 16
)
(
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  mem_pkg::lsu_req_t    i_req,

   // RAM side
   output logic [DRAM_AW-1:0]   o_dram_addr,
   output mem_pkg::byte_en_t    o_dram_we,
   output logic                 o_dram_re,
   output mem_pkg::dword_t      o_dram_din,
   input  mem_pkg::dword_t      i_dram_dout,

   output mem_pkg::wb_t         o_wb
);

   logic [2:0]               lane;
   mem_pkg::byte_en_t        lane_mask;

   logic                     pend_valid;
   logic [2:0]               pend_lane;
   rv_isa_pkg::access_size_t pend_size;
   logic                     pend_sigext;
   rv_isa_pkg::reg_idx_t     pend_rd;

   logic [7:0]               res_8b;
   logic [15:0]              res_16b;
   logic [31:0]              res_32b;
   mem_pkg::wb_t             wb_d;

   // Lanes come from the full request address
   assign lane        = i_req.addr[2:0];
   assign o_dram_addr = {i_req.addr[DRAM_AW-1:3], 3'b000};

   always_comb
   begin
      case (i_req.size)
         rv_isa_pkg::SIZE_B:
            lane_mask = 8'b0000_0001 << lane;
         rv_isa_pkg::SIZE_H:
            lane_mask = 8'b0000_0011 << {lane[2:1], 1'b0};
         rv_isa_pkg::SIZE_W:
            lane_mask = 8'b0000_1111 << {lane[2], 2'b00};
         default:
            lane_mask = 8'b1111_1111;
      endcase
   end

   assign o_dram_we = {8{i_req.valid & i_req.store}} & lane_mask;
   assign o_dram_re = i_req.valid & i_req.load;

   // Store data copied to every lane, the enables pick the bytes
   always_comb
   begin
      case (i_req.size)
         rv_isa_pkg::SIZE_B:
            o_dram_din = {8{i_req.wdata[7:0]}};
         rv_isa_pkg::SIZE_H:
            o_dram_din = {4{i_req.wdata[15:0]}};
         rv_isa_pkg::SIZE_W:
            o_dram_din = {2{i_req.wdata[31:0]}};
         default:
            o_dram_din = i_req.wdata;
      endcase
   end

   // Held while the RAM read is in flight
   always_ff @(posedge i_clk)
   begin
      pend_lane   <= lane;
      pend_size   <= i_req.size;
      pend_sigext <= i_req.sigext;
      pend_rd     <= i_req.rd;
      if (i_rst)
         pend_valid <= 1'b0;
      else
         pend_valid <= o_dram_re;
   end

   assign res_8b  = i_dram_dout[{pend_lane, 3'b000} +: 8];
   assign res_16b = i_dram_dout[{pend_lane[2:1], 4'b0000} +: 16];
   assign res_32b = pend_lane[2] ? i_dram_dout[63:32] : i_dram_dout[31:0];

   always_comb
   begin
      wb_d.valid = pend_valid;
      wb_d.rd    = pend_rd;
      case (pend_size)
         rv_isa_pkg::SIZE_B:
            wb_d.data = {{56{pend_sigext & res_8b[7]}}, res_8b};
         rv_isa_pkg::SIZE_H:
            wb_d.data = {{48{pend_sigext & res_16b[15]}}, res_16b};
         rv_isa_pkg::SIZE_W:
            wb_d.data = {{32{pend_sigext & res_32b[31]}}, res_32b};
         default:
            wb_d.data = i_dram_dout;
      endcase
   end

   always_ff @(posedge i_clk)
   begin
      o_wb <= wb_d;
      if (i_rst)
         o_wb.valid <= 1'b0;
   end

endmodule

// File: hw/dram.sv
`timescale 1ns/100ps

module dram #(
   parameter int DRAM_AW = 16
)
(
   input  logic                i_clk,
   input  logic [DRAM_AW-1:0]  i_addr,
   input  mem_pkg::byte_en_t   i_we,
   input  logic                i_re,
   input  mem_pkg::dword_t     i_din,
   output mem_pkg::dword_t     o_dout
);

   localparam int DEPTH = 2 ** (DRAM_AW - 3);

   mem_pkg::dword_t  mem [DEPTH] = '{default: '0};
   logic [DRAM_AW-4:0] word_idx;

   // Byte address in, word index used
   assign word_idx = i_addr[DRAM_AW-1:3];

   always_ff @(posedge i_clk)
   begin
      for (int b = 0; b < 8; b++)
      begin
         if (i_we[b])
            mem[word_idx][b*8 +: 8] <= i_din[b*8 +: 8];
      end
   end

   // Read data registered, old contents on a same-edge write
   always_ff @(posedge i_clk)
   begin
      if (i_re)
         o_dout <= mem[word_idx];
   end

endmodule

// File: hw/lsu_top.sv
`timescale 1ns/100ps

module lsu_top #(
   parameter int DRAM_AW = 16
)
(
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic                 i_valid,
   input  logic [31:0]          i_insn,
   input  rv_isa_pkg::xlen_t    i_rs1_val,
   input  rv_isa_pkg::xlen_t    i_rs2_val,
   output logic                 o_wb_valid,
   output rv_isa_pkg::reg_idx_t o_wb_rd,
   output rv_isa_pkg::xlen_t    o_wb_data
);

   rv_isa_pkg::lsu_op_t op;
   mem_pkg::lsu_req_t   req;
   mem_pkg::wb_t        wb;

   logic [DRAM_AW-1:0]  dram_addr;
   mem_pkg::byte_en_t   dram_we;
   logic                dram_re;
   mem_pkg::dword_t     dram_din;
   mem_pkg::dword_t     dram_dout;

   lsu_decode u_decode (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_valid   (i_valid),
      .i_insn    (i_insn),
      .i_rs1_val (i_rs1_val),
      .i_rs2_val (i_rs2_val),
      .o_op      (op)
   );

   lsu_agu u_agu (
      .i_clk (i_clk),
      .i_rst (i_rst),
      .i_op  (op),
      .o_req (req)
   );

   lsu #(.DRAM_AW(DRAM_AW)) u_lsu (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_req       (req),
      .o_dram_addr (dram_addr),
      .o_dram_we   (dram_we),
      .o_dram_re   (dram_re),
      .o_dram_din  (dram_din),
      .i_dram_dout (dram_dout),
      .o_wb        (wb)
   );

   dram #(.DRAM_AW(DRAM_AW)) u_dram (
      .i_clk  (i_clk),
      .i_addr (dram_addr),
      .i_we   (dram_we),
      .i_re   (dram_re),
      .i_din  (dram_din),
      .o_dout (dram_dout)
   );

   assign o_wb_valid = wb.valid;
   assign o_wb_rd    = wb.rd;
   assign o_wb_data  = wb.data;

endmodule

// File: testbench/lsu_top_sva.sv
`timescale 1ns/100ps

module lsu_sva (
   input logic              i_clk,
   input logic              i_rst,
   input mem_pkg::lsu_req_t i_req,
   input mem_pkg::byte_en_t o_dram_we,
   input logic              o_dram_re,
   input mem_pkg::wb_t      o_wb
);

   a_we_re_excl: assert property (@(posedge i_clk) disable iff (i_rst)
      !((|o_dram_we) && o_dram_re))
      else $error("RAM write and read enables active in the same cycle");

   a_we_store: assert property (@(posedge i_clk) disable iff (i_rst)
      (|o_dram_we) |-> (i_req.valid && i_req.store))
      else $error("RAM lane enables without a valid store");

   // One lane per byte of the access
   a_we_lanes: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_req.valid && i_req.store) |-> ($countones(o_dram_we) == int'(i_req.size)))
      else $error("Store lane count differs from the access size");

   a_wb_after_rst: assert property (@(posedge i_clk)
      $fell(i_rst) |-> !o_wb.valid)
      else $error("Writeback valid right after reset");

   // Read strobe, then pending register, then writeback
   a_wb_after_load: assert property (@(posedge i_clk) disable iff (i_rst)
      o_wb.valid |-> $past(i_req.valid && i_req.load, 2))
      else $error("Writeback valid without a load ahead of it");

endmodule

bind lsu lsu_sva u_lsu_sva (
   .i_clk     (i_clk),
   .i_rst     (i_rst),
   .i_req     (i_req),
   .o_dram_we (o_dram_we),
   .o_dram_re (o_dram_re),
   .o_wb      (o_wb)
);

// File: testbench/tb_lsu_top.sv
`timescale 1ns/100ps

module tb_lsu_top;

   localparam logic [6:0] OPC_LD  = 7'b0000011;
   localparam logic [6:0] OPC_ST  = 7'b0100011;
   localparam logic [6:0] OPC_ALU = 7'b0010011;

   // Operation codes are {funct3, opcode}
   localparam logic [9:0] OP_LB     = {3'd0, OPC_LD};
   localparam logic [9:0] OP_LW     = {3'd2, OPC_LD};
   localparam logic [9:0] OP_LD     = {3'd3, OPC_LD};
   localparam logic [9:0] OP_SW     = {3'd2, OPC_ST};
   localparam logic [9:0] OP_SD     = {3'd3, OPC_ST};
   localparam logic [9:0] OP_ADDI   = {3'd0, OPC_ALU};
   localparam logic [9:0] OP_BAD_LD = {3'd7, OPC_LD};
   localparam logic [9:0] OP_BAD_ST = {3'd4, OPC_ST};

   localparam int WB_TIMEOUT = 20;
   // Negedges from the driving edge to the sampled writeback
   localparam int LOAD_LAT = 5;

   typedef struct packed {
      logic [9:0]  op;
      logic [4:0]  rd;
      logic [63:0] base;
      logic [63:0] imm;
      logic [63:0] sval;
      logic        idle;
   } row_t;

   typedef struct packed {
      logic [4:0]  rd;
      logic [63:0] data;
      int          due;
      int          idx;
   } exp_t;

   logic        clk;
   logic        i_rst;
   logic        i_valid;
   logic [31:0] i_insn;
   logic [63:0] i_rs1_val;
   logic [63:0] i_rs2_val;
   logic        o_wb_valid;
   logic [4:0]  o_wb_rd;
   logic [63:0] o_wb_data;

   row_t       table_q[$];
   string      row_name[$];
   exp_t       exp_q[$];
   exp_t       head;
   logic [7:0] model [0:65535];
   integer     seed;
   int         errors = 0;
   int         checks = 0;
   int         cyc = 0;
   logic       timed_out;

   lsu_top #(.DRAM_AW(16)) DUT (
      .i_clk      (clk),
      .i_rst      (i_rst),
      .i_valid    (i_valid),
      .i_insn     (i_insn),
      .i_rs1_val  (i_rs1_val),
      .i_rs2_val  (i_rs2_val),
      .o_wb_valid (o_wb_valid),
      .o_wb_rd    (o_wb_rd),
      .o_wb_data  (o_wb_data)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [63:0] rnd64();
      return {$random(seed), $random(seed)};
   endfunction

   function automatic logic [4:0] pick_rd();
      return 5'({$random(seed)} % 31 + 1);
   endfunction

   function automatic logic is_load(input logic [9:0] op);
      return (op[6:0] == OPC_LD) && (op[9:7] != 3'd7);
   endfunction

   function automatic logic is_store(input logic [9:0] op);
      return (op[6:0] == OPC_ST) && !op[9];
   endfunction

   function automatic logic [31:0] encode_insn(input logic [9:0] op, input logic [4:0] rd,
                                               input logic [63:0] imm);
      // S-type splits the immediate, rs1 is x1 and rs2 is x2
      if (op[6:0] == OPC_ST)
         return {imm[11:5], 5'd2, 5'd1, op[9:7], imm[4:0], op[6:0]};
      else
         return {imm[11:0], 5'd1, op[9:7], rd, op[6:0]};
   endfunction

   function automatic logic [63:0] expect_load(input logic [9:0] op, input logic [15:0] addr);
      int          size;
      logic [63:0] val;
      size = 1 << op[8:7];
      val  = '0;
      for (int i = 0; i < size; i++)
         val[i*8 +: 8] = model[addr + 16'(i)];
      // funct3 bit 2 marks the zero-extended forms
      if (!op[9] && size < 8 && val[size*8-1])
         val = val | (~64'd0 << (size * 8));
      return val;
   endfunction

   task automatic store_model(input logic [9:0] op, input logic [15:0] addr,
                              input logic [63:0] sval);
      int size;
      size = 1 << op[8:7];
      for (int i = 0; i < size; i++)
         model[addr + 16'(i)] = sval[i*8 +: 8];
   endtask

   task automatic add_row(input string name, input logic [9:0] op, input logic [4:0] rd,
                          input logic [63:0] base, input logic [63:0] imm,
                          input logic [63:0] sval, input logic idle);
      table_q.push_back('{op: op, rd: rd, base: base, imm: imm, sval: sval, idle: idle});
      row_name.push_back(name);
   endtask

   task automatic build_table();
      int         f;
      int         size;
      int         addr;
      int         imm_i;
      logic [9:0] op;
      int         imm_list [5];
      imm_list = '{-2048, -24, 0, 24, 2040};
      // Every width at every offset, then the whole word
      for (int sz = 1; sz <= 8; sz = sz * 2)
      begin
         for (int off = 0; off < 8; off += sz)
         begin
            op = (sz == 1) ? {3'd0, OPC_ST} : (sz == 2) ? {3'd1, OPC_ST}
               : (sz == 4) ? {3'd2, OPC_ST} : {3'd3, OPC_ST};
            add_row($sformatf("st%0d_o%0d", sz, off), op, 5'd0, 64'h100, 64'(off), rnd64(), 1'b0);
            add_row($sformatf("st%0d_o%0d_chk", sz, off), OP_LD, pick_rd(), 64'h100, 64'd0,
                    64'd0, 1'b1);
         end
      end
      add_row("fill_neg", OP_SD, 5'd0, 64'h200, 64'd0, rnd64() | 64'h8080_8080_8080_8080, 1'b0);
      add_row("fill_pos", OP_SD, 5'd0, 64'h208, 64'd0, rnd64() & 64'h7f7f_7f7f_7f7f_7f7f, 1'b1);
      for (int w = 0; w < 2; w++)
         for (int fl = 0; fl < 7; fl++)
            for (int off = 0; off < 8; off += (1 << fl[1:0]))
               add_row($sformatf("ld_f%0d_w%0d_o%0d", fl, w, off), {3'(fl), OPC_LD}, pick_rd(),
                       64'h200 + 64'(w * 8), 64'(off), 64'd0, 1'b0);
      // Same word reached from two bases
      for (int i = 0; i < 5; i++)
      begin
         add_row($sformatf("agu_st_%0d", imm_list[i]), OP_SD, 5'd0, 64'h4000, 64'(imm_list[i]),
                 rnd64(), 1'b0);
         add_row($sformatf("agu_ld_%0d", imm_list[i]), OP_LD, pick_rd(), 64'h4000,
                 64'(imm_list[i]), 64'd0, 1'b0);
         add_row($sformatf("agu_ldm_%0d", imm_list[i]), OP_LD, pick_rd(),
                 64'h4008 + 64'(imm_list[i]), -64'sd8, 64'd0, 1'b0);
      end
      add_row("flt_ld_a", OP_LD, pick_rd(), 64'h200, 64'd0, 64'd0, 1'b0);
      add_row("flt_addi", OP_ADDI, pick_rd(), 64'h200, 64'd0, 64'd0, 1'b0);
      add_row("flt_ld_b", OP_LW, pick_rd(), 64'h200, 64'd4, 64'd0, 1'b0);
      add_row("flt_bad_ld", OP_BAD_LD, pick_rd(), 64'h200, 64'd0, 64'd0, 1'b0);
      add_row("flt_bad_st", OP_BAD_ST, 5'd0, 64'h200, 64'd0, rnd64(), 1'b0);
      add_row("flt_ld_c", OP_LD, pick_rd(), 64'h200, 64'd0, 64'd0, 1'b1);
      // Store then load of the same word, no gap
      add_row("pipe_sw", OP_SW, 5'd0, 64'h300, 64'd4, rnd64(), 1'b0);
      add_row("pipe_lw", OP_LW, pick_rd(), 64'h300, 64'd4, 64'd0, 1'b0);
      add_row("pipe_sd", OP_SD, 5'd0, 64'h308, 64'd0, rnd64(), 1'b0);
      add_row("pipe_ld", OP_LD, pick_rd(), 64'h308, 64'd0, 64'd0, 1'b0);
      add_row("pipe_lb", OP_LB, pick_rd(), 64'h308, 64'd7, 64'd0, 1'b0);
      for (int n = 0; n < 24; n++)
      begin
         f     = {$random(seed)} % 11;
         op    = (f < 7) ? {3'(f), OPC_LD} : {3'(f - 7), OPC_ST};
         size  = 1 << op[8:7];
         addr  = ({$random(seed)} % 65536) & ~(size - 1);
         imm_i = $random(seed) % 256;
         add_row($sformatf("rand_%0d", n), op, pick_rd(), 64'(addr) - 64'(imm_i), 64'(imm_i),
                 rnd64(), 1'b0);
      end
   endtask

   task automatic init_inputs();
      i_rst     <= 1'b1;
      i_valid   <= 1'b0;
      i_insn    <= 32'd0;
      i_rs1_val <= 64'd0;
      i_rs2_val <= 64'd0;
   endtask

   task automatic end_reset();
      i_rst <= 1'b0;
   endtask

   task automatic drive_idle();
      @(posedge clk);
      i_valid <= 1'b0;
   endtask

   task automatic apply_row(input int idx);
      row_t        r;
      logic [15:0] ea;
      exp_t        e;
      r  = table_q[idx];
      ea = 16'(r.base + r.imm);
      @(posedge clk);
      i_valid   <= 1'b1;
      i_insn    <= encode_insn(r.op, r.rd, r.imm);
      i_rs1_val <= r.base;
      i_rs2_val <= r.sval;
      if (is_load(r.op))
      begin
         e.rd   = r.rd;
         e.data = expect_load(r.op, ea);
         e.due  = cyc + LOAD_LAT;
         e.idx  = idx;
         exp_q.push_back(e);
      end
      else if (is_store(r.op))
         store_model(r.op, ea, r.sval);
      if (r.idle)
         drive_idle();
   endtask

   task automatic drain();
      int wait_cnt;
      wait_cnt  = 0;
      timed_out = 1'b0;
      while (exp_q.size() > 0 && wait_cnt < WB_TIMEOUT)
      begin
         @(posedge clk);
         wait_cnt++;
      end
      assert (exp_q.size() == 0) else
      begin
         $display("Timed out, %0d load writebacks never came", exp_q.size());
         timed_out = 1'b1;
      end
   endtask

   // Writebacks checked half a cycle after the edge
   always @(negedge clk)
   begin
      cyc = cyc + 1;
      if (o_wb_valid)
      begin
         assert (exp_q.size() > 0) else
         begin
            $display("Writeback to x%0d arrived with no load pending", o_wb_rd);
            errors++;
         end
         if (exp_q.size() > 0)
         begin
            head = exp_q.pop_front();
            checks++;
            assert (o_wb_data == head.data) else
            begin
               $display("error %s data expected %h actual %h", row_name[head.idx], head.data,
                        o_wb_data);
               errors++;
            end
            assert (o_wb_rd == head.rd) else
            begin
               $display("error %s rd expected %0d actual %0d", row_name[head.idx], head.rd,
                        o_wb_rd);
               errors++;
            end
            assert (cyc == head.due) else
            begin
               $display("error %s cycle expected %0d actual %0d", row_name[head.idx], head.due,
                        cyc);
               errors++;
            end
         end
      end
      else if (exp_q.size() > 0 && cyc > exp_q[0].due)
      begin
         $display("Writeback for %s never came", row_name[exp_q[0].idx]);
         errors++;
         void'(exp_q.pop_front());
      end
   end

   initial
   begin
      seed  = 32'h56b00e5c;
      model = '{default: 8'h00};
      init_inputs();
      build_table();
      repeat (4) @(posedge clk);
      end_reset();
      // Idle cycles after reset, no writeback allowed
      repeat (3) @(posedge clk);
      for (int r = 0; r < table_q.size(); r++)
         apply_row(r);
      drive_idle();
      drain();
      repeat (4) @(posedge clk);
      $display("Loads checked %0d, errors %0d, timeouts %0d", checks, errors, int'(timed_out));
      if (errors == 0 && !timed_out)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

// File: list.f
hw/rv_isa_pkg.sv
hw/mem_pkg.sv
hw/lsu_decode.sv
hw/lsu_agu.sv
hw/lsu.sv
hw/dram.sv
hw/lsu_top.sv
testbench/lsu_top_sva.sv
testbench/tb_lsu_top.sv

// File: run.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_lsu_top \
   -f list.f -Mdir obj_dir -o sim_lsu
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/sim_lsu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qF "** FAIL **" sim.log; then
   echo "Failure reported in sim.log"
   exit 1
fi

exit 0
